/* axi_pkg.sv */
package axi_pkg;

  // ==================================================
  // Burst and response encodings
  // ==================================================

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // ==================================================
  // Read channel payloads
  // ==================================================

  // Read address payload that travels with ar_valid.
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  id;
    logic [7:0]  len;    // Beats minus one.
    logic [2:0]  size;
    logic [1:0]  burst;
  } ar_req_t;

  // One read data beat.
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
    logic [3:0]  id;
  } r_beat_t;

endpackage

/* soc_pkg.sv */
package soc_pkg;

  // ==================================================
  // Address map
  // ==================================================

  localparam logic [15:0] CLINT_BASE_HI = 16'h0200;  // Upper half of a CLINT address.

  localparam int          MEM_WORDS = 64;
  localparam int          MEM_AW    = $clog2(MEM_WORDS);
  localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
  localparam logic [31:0] MEM_END   = MEM_BASE + 32'(4 * MEM_WORDS);  // First byte past memory.

  // CLINT register offsets within its 64 KiB window.
  localparam logic [15:0] MTIME_LO_OFF = 16'hBFF8;
  localparam logic [15:0] MTIME_HI_OFF = 16'hBFFC;

endpackage

/* read_xbar.sv */
`timescale 1ns/100ps

module read_xbar (
  input  logic             clock,
  input  logic             reset,

  input  logic             up_ar_valid,
  input  axi_pkg::ar_req_t up_ar,
  output logic             up_ar_ready,
  output logic             up_r_valid,
  output axi_pkg::r_beat_t up_r,
  input  logic             up_r_ready,

  output logic             mem_ar_valid,
  output axi_pkg::ar_req_t mem_ar,
  input  logic             mem_ar_ready,
  input  logic             mem_r_valid,
  input  axi_pkg::r_beat_t mem_r,
  output logic             mem_r_ready,

  output logic             clint_ar_valid,
  output axi_pkg::ar_req_t clint_ar,
  input  logic             clint_ar_ready,
  input  logic             clint_r_valid,
  input  axi_pkg::r_beat_t clint_r,
  output logic             clint_r_ready
);

  import axi_pkg::*;
  import soc_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'b001,
    ST_MEM   = 3'b010,
    ST_CLINT = 3'b100
  } state_t;

  state_t  state;
  state_t  state_next;
  logic    st_idle;
  logic    st_mem;
  logic    st_clint;
  logic    req_clint;
  logic    sel_r_valid;
  r_beat_t sel_r;

  assign st_idle   = state[0];
  assign st_mem    = state[1];
  assign st_clint  = state[2];
  assign req_clint = (up_ar.addr[31:16] == CLINT_BASE_HI);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    if (st_idle) begin
      if (up_ar_valid && up_ar_ready) begin
        state_next = req_clint ? ST_CLINT : ST_MEM;
      end
    end else if (up_r_valid && up_r_ready && up_r.last) begin
      state_next = ST_IDLE;  // Released once the last beat has gone up.
    end
  end

  // ==================================================
  // Address channel open only while idle
  // ==================================================

  assign mem_ar_valid   = st_idle & ~req_clint & up_ar_valid;
  assign clint_ar_valid = st_idle & req_clint & up_ar_valid;
  assign mem_ar         = (st_idle && !req_clint) ? up_ar : '0;
  assign clint_ar       = (st_idle && req_clint) ? up_ar : '0;
  assign up_ar_ready    = st_idle & (req_clint ? clint_ar_ready : mem_ar_ready);

  // ==================================================
  // Data channel following the locked slave
  // ==================================================

  always_comb begin
    sel_r_valid = 1'b0;
    sel_r       = '0;
    if (st_mem) begin
      sel_r_valid = mem_r_valid;
      sel_r       = mem_r;
    end else if (st_clint) begin
      sel_r_valid = clint_r_valid;
      sel_r       = clint_r;
    end
  end

  assign up_r_valid    = sel_r_valid;
  assign up_r          = sel_r;
  assign mem_r_ready   = st_mem & up_r_ready;
  assign clint_r_ready = st_clint & up_r_ready;

endmodule

/* soc_mem.sv */
`timescale 1ns/100ps

module soc_mem (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  axi_pkg::ar_req_t ar,
  output logic             ar_ready,
  output logic             r_valid,
  output axi_pkg::r_beat_t r,
  input  logic             r_ready
);

  import axi_pkg::*;
  import soc_pkg::*;

  logic [31:0]       mem [MEM_WORDS];
  logic [7:0]        beats_left;      // Beats still to come after the current one.
  logic [MEM_AW-1:0] word_addr;
  logic [MEM_AW-1:0] next_addr;
  logic [1:0]        burst;
  logic              decerr;
  logic              in_window;
  logic              ar_fire;
  logic              r_fire;

  initial begin
    $readmemh("mem_init.hex", mem);
  end

  assign ar_ready  = ~r_valid;  // A burst is open exactly while a beat is pending.
  assign ar_fire   = ar_valid & ar_ready;
  assign r_fire    = r_valid & r_ready;
  assign in_window = (ar.addr >= MEM_BASE) && (ar.addr < MEM_END);

  always_comb begin
    case (burst)
      BURST_INCR:  next_addr = word_addr + MEM_AW'(1);
      BURST_FIXED: next_addr = word_addr;
      default:     next_addr = word_addr;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid    <= 1'b0;
      beats_left <= '0;
    end else if (ar_fire) begin
      r_valid    <= 1'b1;
      beats_left <= ar.len;
    end else if (r_fire) begin
      r_valid    <= ~r.last;
      beats_left <= beats_left - 8'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      word_addr <= ar.addr[MEM_AW+1:2];
      burst     <= ar.burst;
      decerr    <= ~in_window;
      r.data    <= in_window ? mem[ar.addr[MEM_AW+1:2]] : 32'h0;
      r.resp    <= in_window ? RESP_OKAY : RESP_DECERR;
      r.last    <= (ar.len == 8'd0);
      r.id      <= ar.id;
    end else if (r_fire && !r.last) begin
      word_addr <= next_addr;
      r.data    <= decerr ? 32'h0 : mem[next_addr];
      r.last    <= (beats_left == 8'd1);
    end
  end

endmodule

/* clint.sv */
`timescale 1ns/100ps

module clint (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  axi_pkg::ar_req_t ar,
  output logic             ar_ready,
  output logic             r_valid,
  output axi_pkg::r_beat_t r,
  input  logic             r_ready
);

  import axi_pkg::*;
  import soc_pkg::*;

  logic [63:0] mtime;
  logic [15:0] offset;
  logic [15:0] sel_off;
  logic [7:0]  beats_left;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic        ar_fire;
  logic        r_fire;

  assign ar_ready = ~r_valid;
  assign ar_fire  = ar_valid & ar_ready;
  assign r_fire   = r_valid & r_ready;

  always_comb begin
    sel_off = r_valid ? offset : ar.addr[15:0];  // The burst keeps its first address.
    rd_data = 32'h0;
    rd_resp = RESP_SLVERR;
    case (sel_off)
      MTIME_LO_OFF: begin
        rd_data = mtime[31:0];
        rd_resp = RESP_OKAY;
      end
      MTIME_HI_OFF: begin
        rd_data = mtime[63:32];
        rd_resp = RESP_OKAY;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime      <= 64'h0;
      r_valid    <= 1'b0;
      beats_left <= '0;
    end else begin
      mtime <= mtime + 64'd1;
      if (ar_fire) begin
        r_valid    <= 1'b1;
        beats_left <= ar.len;
      end else if (r_fire) begin
        r_valid    <= ~r.last;
        beats_left <= beats_left - 8'd1;
      end
    end
  end

  // Every beat takes a fresh sample of the timer.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      offset <= ar.addr[15:0];
      r.data <= rd_data;
      r.resp <= rd_resp;
      r.last <= (ar.len == 8'd0);
      r.id   <= ar.id;
    end else if (r_fire && !r.last) begin
      r.data <= rd_data;
      r.resp <= rd_resp;
      r.last <= (beats_left == 8'd1);
    end
  end

endmodule

/* read_subsystem.sv */
`timescale 1ns/100ps

module read_subsystem (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  input  axi_pkg::ar_req_t ar,
  output logic             ar_ready,
  output logic             r_valid,
  output axi_pkg::r_beat_t r,
  input  logic             r_ready
);

  import axi_pkg::*;

  // ==================================================
  // Crossbar to slave links
  // ==================================================

  logic    mem_ar_valid;
  ar_req_t mem_ar;
  logic    mem_ar_ready;
  logic    mem_r_valid;
  r_beat_t mem_r;
  logic    mem_r_ready;

  logic    clint_ar_valid;
  ar_req_t clint_ar;
  logic    clint_ar_ready;
  logic    clint_r_valid;
  r_beat_t clint_r;
  logic    clint_r_ready;

  read_xbar xbar (
    .clock          (clock),
    .reset          (reset),
    .up_ar_valid    (ar_valid),
    .up_ar          (ar),
    .up_ar_ready    (ar_ready),
    .up_r_valid     (r_valid),
    .up_r           (r),
    .up_r_ready     (r_ready),
    .mem_ar_valid   (mem_ar_valid),
    .mem_ar         (mem_ar),
    .mem_ar_ready   (mem_ar_ready),
    .mem_r_valid    (mem_r_valid),
    .mem_r          (mem_r),
    .mem_r_ready    (mem_r_ready),
    .clint_ar_valid (clint_ar_valid),
    .clint_ar       (clint_ar),
    .clint_ar_ready (clint_ar_ready),
    .clint_r_valid  (clint_r_valid),
    .clint_r        (clint_r),
    .clint_r_ready  (clint_r_ready)
  );

  soc_mem mem (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (mem_ar_valid),
    .ar       (mem_ar),
    .ar_ready (mem_ar_ready),
    .r_valid  (mem_r_valid),
    .r        (mem_r),
    .r_ready  (mem_r_ready)
  );

  clint clint_i (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (clint_ar_valid),
    .ar       (clint_ar),
    .ar_ready (clint_ar_ready),
    .r_valid  (clint_r_valid),
    .r        (clint_r),
    .r_ready  (clint_r_ready)
  );

endmodule

/* read_subsystem_chk.sv */
`timescale 1ns/100ps

module read_subsystem_chk (
  input logic             clock,
  input logic             reset,
  input logic             ar_valid,
  input axi_pkg::ar_req_t ar,
  input logic             ar_ready,
  input logic             r_valid,
  input axi_pkg::r_beat_t r,
  input logic             r_ready
);

  logic       burst_open;
  logic [8:0] beats_due;  // Beats still owed including the pending one.
  int         stable_fails = 0;
  int         stray_fails  = 0;
  int         ar_fails     = 0;
  int         count_fails  = 0;
  int         fail_count;

  assign fail_count = stable_fails + stray_fails + ar_fails + count_fails;

  always_ff @(posedge clock) begin
    if (reset) begin
      burst_open <= 1'b0;
      beats_due  <= '0;
    end else if (ar_valid && ar_ready) begin
      burst_open <= 1'b1;
      beats_due  <= {1'b0, ar.len} + 9'd1;
    end else if (r_valid && r_ready) begin
      beats_due <= beats_due - 9'd1;
      if (r.last) begin
        burst_open <= 1'b0;
      end
    end
  end

  // ==================================================
  // Read channel rules
  // ==================================================

  assert property (@(posedge clock) disable iff (reset)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)))
  else begin
    $error("r_valid or r changed while r_ready was low");
    stable_fails++;
  end

  assert property (@(posedge clock) disable iff (reset) r_valid |-> burst_open)
  else begin
    $error("r_valid raised with no burst outstanding");
    stray_fails++;
  end

  assert property (@(posedge clock) disable iff (reset) burst_open |-> !ar_ready)
  else begin
    $error("ar_ready high while a burst is still open");
    ar_fails++;
  end

  // The last flag must land exactly on beat len+1.
  assert property (@(posedge clock) disable iff (reset)
    (r_valid && r_ready) |-> (r.last == (beats_due == 9'd1)))
  else begin
    $error("burst beat count does not match len+1");
    count_fails++;
  end

endmodule

bind read_subsystem read_subsystem_chk chk (
  .clock    (clock),
  .reset    (reset),
  .ar_valid (ar_valid),
  .ar       (ar),
  .ar_ready (ar_ready),
  .r_valid  (r_valid),
  .r        (r),
  .r_ready  (r_ready)
);

/* tb_read_subsystem.sv */
`timescale 1ns/100ps

module tb_read_subsystem;

  import axi_pkg::*;
  import soc_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int RANDOM_BURSTS  = 12;

  logic        clock;
  logic        reset;
  logic        ar_valid;
  ar_req_t     ar;
  logic        ar_ready;
  logic        r_valid;
  r_beat_t     r;
  logic        r_ready;

  logic [31:0] ref_mem [MEM_WORDS];
  logic [31:0] last_timer;  // Latest mtime low half seen.
  int          errors;
  bit          timed_out;

  read_subsystem dut (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready)
  );

  always #20 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s expected 0x%08h got 0x%08h", name, expected, actual);
    end
  endtask

  task automatic check_timer_rises(input logic [31:0] actual);
    assert (actual > last_timer) else begin
      errors++;
      $display("Fail r.data expected above 0x%08h got 0x%08h", last_timer, actual);
    end
    last_timer = actual;
  endtask

  // ==================================================
  // Reference model of the address map and memory
  // ==================================================

  function automatic void predict_beat(
    input  logic [31:0] addr,
    input  logic [1:0]  burst,
    input  int          beat,
    output logic [31:0] data,
    output logic [1:0]  resp,
    output bit          timer_lo
  );
    logic [MEM_AW-1:0] word;
    data     = 32'h0;
    timer_lo = 1'b0;
    if (addr[31:16] == CLINT_BASE_HI) begin
      timer_lo = (addr[15:0] == MTIME_LO_OFF);
      resp     = (timer_lo || addr[15:0] == MTIME_HI_OFF) ? RESP_OKAY : RESP_SLVERR;
    end else if (addr >= MEM_BASE && addr < MEM_END) begin
      word = addr[MEM_AW+1:2];
      if (burst == BURST_INCR) begin
        word = word + MEM_AW'(beat);
      end
      data = ref_mem[word];
      resp = RESP_OKAY;
    end else begin
      resp = RESP_DECERR;
    end
  endfunction

  // One burst from address handshake to last beat; outputs sampled mid cycle.
  task automatic run_burst(
    input logic [31:0] addr,
    input logic [3:0]  id,
    input logic [7:0]  len,
    input logic [1:0]  burst,
    input bit          random_ready
  );
    int          beat;
    int          wait_cycles;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    bit          timer_lo;
    if (!timed_out) begin
      @(negedge clock);
      ar_valid = 1'b1;
      ar.addr  = addr;
      ar.id    = id;
      ar.len   = len;
      ar.size  = 3'd2;
      ar.burst = burst;
      wait_cycles = 0;
      #5;
      while (!ar_ready && !timed_out) begin
        wait_cycles++;
        if (wait_cycles > TIMEOUT_CYCLES) begin
          $display("Timeout waiting for ar_ready on address 0x%08h", addr);
          timed_out = 1'b1;
        end
        @(negedge clock);
        #5;
      end
      @(negedge clock);
      ar_valid    = 1'b0;
      ar          = '0;
      beat        = 0;
      wait_cycles = 0;
      while (beat <= int'(len) && !timed_out) begin
        r_ready = random_ready ? 1'($urandom % 2) : 1'b1;
        #5;
        if (r_valid && r_ready) begin
          predict_beat(addr, burst, beat, exp_data, exp_resp, timer_lo);
          if (timer_lo) begin
            check_timer_rises(r.data);
          end else begin
            check_value("r.data", exp_data, r.data);
          end
          check_value("r.resp", 32'(exp_resp), 32'(r.resp));
          check_value("r.last", 32'(beat == int'(len)), 32'(r.last));
          check_value("r.id", 32'(id), 32'(r.id));
          beat++;
          wait_cycles = 0;
        end else begin
          wait_cycles++;
          if (wait_cycles > TIMEOUT_CYCLES) begin
            $display("Timeout waiting for beat %0d from address 0x%08h", beat, addr);
            timed_out = 1'b1;
          end
        end
        @(negedge clock);
      end
      r_ready = 1'b0;
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================

  initial begin
    logic [31:0] addr;
    logic [7:0]  len;
    int          kind;
    int          total;
    void'($urandom(99035));
    $readmemh("mem_init.hex", ref_mem);
    clock      = 1'b0;
    reset      = 1'b1;
    ar_valid   = 1'b0;
    ar         = '0;
    r_ready    = 1'b0;
    errors     = 0;
    timed_out  = 1'b0;
    last_timer = 32'h0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    run_burst(MEM_BASE + 32'h0C, 4'h3, 8'd7, BURST_INCR, 1'b0);
    run_burst(MEM_BASE + 32'h28, 4'h5, 8'd5, BURST_FIXED, 1'b0);
    run_burst(MEM_END + 32'h40, 4'h9, 8'd3, BURST_INCR, 1'b0);  // Past the last word.

    run_burst({CLINT_BASE_HI, MTIME_LO_OFF}, 4'h1, 8'd0, BURST_INCR, 1'b0);
    repeat (4) @(negedge clock);
    run_burst({CLINT_BASE_HI, MTIME_LO_OFF}, 4'h2, 8'd0, BURST_INCR, 1'b0);
    run_burst({CLINT_BASE_HI, MTIME_HI_OFF}, 4'h6, 8'd1, BURST_INCR, 1'b0);
    run_burst({CLINT_BASE_HI, 16'h0010}, 4'hA, 8'd2, BURST_INCR, 1'b0);

    for (int i = 0; i < RANDOM_BURSTS; i++) begin
      kind = int'($urandom % 3);
      len  = 8'($urandom % 8);
      addr = MEM_BASE + 32'(4 * ($urandom % (MEM_WORDS - 7)));
      if (kind == 2) begin
        run_burst({CLINT_BASE_HI, MTIME_LO_OFF}, 4'(i), len, BURST_INCR, 1'b1);
      end else begin
        run_burst(addr, 4'(i), len, (kind == 0) ? BURST_INCR : BURST_FIXED, 1'b1);
      end
    end

    repeat (2) @(negedge clock);
    total = errors + dut.chk.fail_count;
    $display("Errors %0d in testbench checks and %0d in protocol assertions",
             errors, dut.chk.fail_count);
    if (!timed_out && total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      if (timed_out) begin
        $display("The run stopped early on a timeout");
      end
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* mem_init.hex */
// One 32-bit word per line in hex, for word addresses 0 to 63 in order.
AA00553F
AA01553E
AA02553D
AA03553C
AA04553B
AA05553A
AA065539
AA075538
AA085537
AA095536
AA0A5535
AA0B5534
AA0C5533
AA0D5532
AA0E5531
AA0F5530
AA10552F
AA11552E
AA12552D
AA13552C
AA14552B
AA15552A
AA165529
AA175528
AA185527
AA195526
AA1A5525
AA1B5524
AA1C5523
AA1D5522
AA1E5521
AA1F5520
AA20551F
AA21551E
AA22551D
AA23551C
AA24551B
AA25551A
AA265519
AA275518
AA285517
AA295516
AA2A5515
AA2B5514
AA2C5513
AA2D5512
AA2E5511
AA2F5510
AA30550F
AA31550E
AA32550D
AA33550C
AA34550B
AA35550A
AA365509
AA375508
AA385507
AA395506
AA3A5505
AA3B5504
AA3C5503
AA3D5502
AA3E5501
AA3F5500

/* tb.f */
axi_pkg.sv
soc_pkg.sv
read_xbar.sv
soc_mem.sv
clint.sv
read_subsystem.sv
read_subsystem_chk.sv
tb_read_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_read_subsystem
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) mem_init.hex
	$(SIM) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
